//--- verilog/rx_lane_defs.svh
////////////////////////////////////////
// RX lane reset sequencer constants
// Phase lengths in clk cycles and the
// width of the shared phase timer
////////////////////////////////////////
`ifndef RX_LANE_DEFS_SVH
`define RX_LANE_DEFS_SVH

// Timed phases
`define RXL_PD_CYCLES        16  // Lane held powered down
`define RXL_PMA_CYCLES       4   // PMA reset pulse
`define RXL_CDR_CYCLES       40  // Time-out for CDR lock
`define RXL_PCS_CYCLES       8   // PCS reset pulse
`define RXL_ALIGN_CYCLES     24  // Time-out for word alignment
`define RXL_DONE_DLY_CYCLES  6   // Settling delay before done

// Phase timer width
// Must hold the largest phase length above
`define RXL_TMR_W            6

`endif

//--- verilog/rx_lane_pkg.sv
////////////////////////////////////////
// RX lane reset sequencer types
// State encoding shared by all blocks
////////////////////////////////////////
package rx_lane_pkg;

    // Sequencer states, in bring-up order
    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_PD         = 4'd1,  // Lane powered down
        ST_PMA_RST    = 4'd2,
        ST_SIG_WAIT   = 4'd3,  // Waiting for signal detect
        ST_CDR_WAIT   = 4'd4,
        ST_PCS_RST    = 4'd5,
        ST_ALIGN_WAIT = 4'd6,
        ST_DONE_DLY   = 4'd7,
        ST_DONE       = 4'd8
    } rx_lane_state_e;

endpackage

//--- verilog/rx_lane_timer.sv
////////////////////////////////////////
// RX lane phase timer
// Counts cycles in the current state and
// flags the last cycle of a timed phase
////////////////////////////////////////
`include "rx_lane_defs.svh"

module rx_lane_timer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rx_lane_pkg::rx_lane_state_e i_state,
    output logic                        o_expired
);
    import rx_lane_pkg::*;

    // Last count value of each timed phase
    localparam logic [`RXL_TMR_W-1:0] PD_LAST    = `RXL_TMR_W'(`RXL_PD_CYCLES - 1);
    localparam logic [`RXL_TMR_W-1:0] PMA_LAST   = `RXL_TMR_W'(`RXL_PMA_CYCLES - 1);
    localparam logic [`RXL_TMR_W-1:0] CDR_LAST   = `RXL_TMR_W'(`RXL_CDR_CYCLES - 1);
    localparam logic [`RXL_TMR_W-1:0] PCS_LAST   = `RXL_TMR_W'(`RXL_PCS_CYCLES - 1);
    localparam logic [`RXL_TMR_W-1:0] ALIGN_LAST = `RXL_TMR_W'(`RXL_ALIGN_CYCLES - 1);
    localparam logic [`RXL_TMR_W-1:0] DLY_LAST   = `RXL_TMR_W'(`RXL_DONE_DLY_CYCLES - 1);

    rx_lane_state_e          prev_state;
    logic [`RXL_TMR_W-1:0]   cnt;
    logic [`RXL_TMR_W-1:0]   cnt_cur;   // Count seen this cycle
    logic [`RXL_TMR_W-1:0]   last_cnt;
    logic                    timed;

    ////////////////////////////////////////
    // Phase limit lookup
    ////////////////////////////////////////
    always_comb
    begin
        timed    = 1'b1;
        last_cnt = '0;
        case (i_state)
            ST_PD:         last_cnt = PD_LAST;
            ST_PMA_RST:    last_cnt = PMA_LAST;
            ST_CDR_WAIT:   last_cnt = CDR_LAST;
            ST_PCS_RST:    last_cnt = PCS_LAST;
            ST_ALIGN_WAIT: last_cnt = ALIGN_LAST;
            ST_DONE_DLY:   last_cnt = DLY_LAST;
            default:       timed    = 1'b0;  // Untimed, never expires
        endcase
    end

    // Zero on the first cycle of a new state
    assign cnt_cur   = (i_state != prev_state) ? '0 : cnt;
    assign o_expired = timed && (cnt_cur == last_cnt);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prev_state <= ST_IDLE;
            cnt        <= '0;
        end
        else
        begin
            prev_state <= i_state;
            if (cnt_cur == '1)
            begin
                cnt <= cnt_cur;            // Hold in long waits
            end
            else
            begin
                cnt <= cnt_cur + 1'b1;
            end
        end
    end

endmodule

//--- verilog/rx_lane_seq.sv
////////////////////////////////////////
// RX lane reset sequencer FSM
// Walks power-down, PMA reset, CDR lock,
// PCS reset and alignment, then done
////////////////////////////////////////
module rx_lane_seq (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_sigdet,
    input  logic                        i_cdr_align,
    input  logic                        i_word_align,
    input  logic                        i_expired,
    output rx_lane_pkg::rx_lane_state_e o_state
);
    import rx_lane_pkg::*;

    rx_lane_state_e next_state;
    logic           link_lost;

    // Signal or lock gone after the CDR wait
    assign link_lost = !i_sigdet || !i_cdr_align;

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_state <= ST_IDLE;
        end
        else
        begin
            o_state <= next_state;
        end
    end

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    always_comb
    begin
        next_state = o_state;
        case (o_state)
            ST_IDLE:
            begin
                next_state = ST_PD;
            end
            ST_PD:
            begin
                if (i_expired)
                    next_state = ST_PMA_RST;
            end
            ST_PMA_RST:
            begin
                if (i_expired)
                    next_state = ST_SIG_WAIT;
            end
            ST_SIG_WAIT:
            begin
                if (i_sigdet)
                    next_state = ST_CDR_WAIT;
            end
            ST_CDR_WAIT:
            begin
                if (!i_sigdet || i_expired)
                    next_state = ST_PMA_RST;   // Signal gone or no lock in time
                else if (i_cdr_align)
                    next_state = ST_PCS_RST;
            end
            ST_PCS_RST:
            begin
                if (link_lost)
                    next_state = ST_PMA_RST;
                else if (i_expired)
                    next_state = ST_ALIGN_WAIT;
            end
            ST_ALIGN_WAIT:
            begin
                if (link_lost)
                    next_state = ST_PMA_RST;
                else if (i_word_align)
                    next_state = ST_DONE_DLY;
                else if (i_expired)
                    next_state = ST_PMA_RST;   // Alignment time-out
            end
            ST_DONE_DLY:
            begin
                if (link_lost)
                    next_state = ST_PMA_RST;
                else if (i_expired)
                    next_state = ST_DONE;
            end
            ST_DONE:
            begin
                if (link_lost)
                    next_state = ST_PMA_RST;
            end
            default:
            begin
                next_state = ST_IDLE;
            end
        endcase
    end

endmodule

//--- verilog/rx_lane_ctrl.sv
////////////////////////////////////////
// RX lane reset outputs
// Registered decode of the sequencer state
////////////////////////////////////////
module rx_lane_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rx_lane_pkg::rx_lane_state_e i_state,
    output logic                        o_lane_pd,
    output logic                        o_pma_rst,
    output logic                        o_pcs_rst,
    output logic                        o_lane_done
);
    import rx_lane_pkg::*;

    logic pd_release;
    logic pma_rst_nxt;
    logic pcs_rst_nxt;

    // Any state beyond power-down releases the lane
    assign pd_release = !(i_state inside {ST_IDLE, ST_PD});

    assign pma_rst_nxt = i_state inside {ST_IDLE, ST_PD, ST_PMA_RST};

    // PCS held until alignment starts
    assign pcs_rst_nxt = i_state inside {ST_IDLE, ST_PD, ST_PMA_RST,
                                         ST_SIG_WAIT, ST_CDR_WAIT, ST_PCS_RST};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_lane_pd   <= 1'b1;
            o_pma_rst   <= 1'b1;
            o_pcs_rst   <= 1'b1;
            o_lane_done <= 1'b0;
        end
        else
        begin
            if (pd_release)
            begin
                o_lane_pd <= 1'b0;   // Sticky until reset
            end
            o_pma_rst   <= pma_rst_nxt;
            o_pcs_rst   <= pcs_rst_nxt;
            o_lane_done <= (i_state == ST_DONE);
        end
    end

endmodule

//--- verilog/rx_lane_rst.sv
////////////////////////////////////////
// RX lane reset sequencer top
// Sequencer, phase timer and outputs
////////////////////////////////////////
module rx_lane_rst (
    input  logic clk,
    input  logic rst_n,
    input  logic i_sigdet,
    input  logic i_cdr_align,
    input  logic i_word_align,
    output logic o_lane_pd,
    output logic o_pma_rst,
    output logic o_pcs_rst,
    output logic o_lane_done
);
    import rx_lane_pkg::*;

    rx_lane_state_e state;
    logic           expired;   // Current phase at its last cycle

    rx_lane_seq u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_sigdet     (i_sigdet),
        .i_cdr_align  (i_cdr_align),
        .i_word_align (i_word_align),
        .i_expired    (expired),
        .o_state      (state)
    );

    rx_lane_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_state   (state),
        .o_expired (expired)
    );

    rx_lane_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_state     (state),
        .o_lane_pd   (o_lane_pd),
        .o_pma_rst   (o_pma_rst),
        .o_pcs_rst   (o_pcs_rst),
        .o_lane_done (o_lane_done)
    );

endmodule

//--- tests/rx_lane_rst_assert.sv
////////////////////////////////////////
// RX lane reset sequencer checks
// Concurrent assertions on the outputs,
// bound into the sequencer top level
////////////////////////////////////////
`include "rx_lane_defs.svh"

module rx_lane_rst_assert (
    input  logic clk,
    input  logic rst_n,
    input  logic i_sigdet,
    input  logic i_cdr_align,
    input  logic i_word_align,
    input  logic o_lane_pd,
    input  logic o_pma_rst,
    input  logic o_pcs_rst,
    input  logic o_lane_done
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam int PD_FALL   = `RXL_PD_CYCLES + 2;
    localparam int ALIGN_WIN = `RXL_ALIGN_CYCLES + 2;
    localparam int DONE_WIN  = `RXL_PD_CYCLES + `RXL_PMA_CYCLES + `RXL_CDR_CYCLES
                             + `RXL_PCS_CYCLES + `RXL_ALIGN_CYCLES + `RXL_DONE_DLY_CYCLES + 8;

    int fail_cnt = 0;   // Read by the testbench at the end

    logic clk_seen = 1'b0;   // Outputs settle on the first edge under reset

    always @(posedge clk)
    begin
        clk_seen <= 1'b1;
    end

    // Reset values, during reset and first cycle after
    a_rst_vals: assert property (@(posedge clk)
            (clk_seen && (!rst_n || $rose(rst_n))) |->
            (o_lane_pd && o_pma_rst && o_pcs_rst && !o_lane_done))
        else
        begin
            fail_cnt++;
            $error("Outputs not at reset values");
        end

    // Power-down release time
    a_pd_fall: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(rst_n) |-> o_lane_pd [*PD_FALL] ##1 !o_lane_pd)
        else
        begin
            fail_cnt++;
            $error("o_lane_pd released at wrong cycle");
        end

    a_pd_sticky: assert property (@(posedge clk) disable iff (!rst_n)
            !o_lane_pd |=> !o_lane_pd)
        else
        begin
            fail_cnt++;
            $error("o_lane_pd rose again before reset");
        end

    // Done only with resets released and link good
    a_done_ok: assert property (@(posedge clk) disable iff (!rst_n)
            o_lane_done |-> (!o_pma_rst && !o_pcs_rst &&
                             $past(i_sigdet, 2) && $past(i_cdr_align, 2)))
        else
        begin
            fail_cnt++;
            $error("o_lane_done high in a bad condition");
        end

    a_link_loss: assert property (@(posedge clk) disable iff (!rst_n)
            (($fell(i_sigdet) || $fell(i_cdr_align)) && o_lane_done) |->
            ##2 (!o_lane_done && o_pma_rst))
        else
        begin
            fail_cnt++;
            $error("No restart two cycles after link loss");
        end

    // Alignment time-out restarts the PMA
    a_align_tmo: assert property (@(posedge clk) disable iff (!rst_n)
            ($fell(o_pcs_rst) && !i_word_align) |->
            (!o_lane_done throughout ##[1:ALIGN_WIN] o_pma_rst))
        else
        begin
            fail_cnt++;
            $error("No restart after alignment time-out");
        end

    a_bring_up: assert property (@(posedge clk) disable iff (!rst_n)
            ($fell(o_lane_pd) && i_sigdet && i_cdr_align && i_word_align) |->
            ##[1:DONE_WIN] o_lane_done)
        else
        begin
            fail_cnt++;
            $error("o_lane_done late after power-down release");
        end

endmodule

bind rx_lane_rst rx_lane_rst_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_sigdet     (i_sigdet),
    .i_cdr_align  (i_cdr_align),
    .i_word_align (i_word_align),
    .o_lane_pd    (o_lane_pd),
    .o_pma_rst    (o_pma_rst),
    .o_pcs_rst    (o_pcs_rst),
    .o_lane_done  (o_lane_done)
);

//--- tests/rx_lane_rst_tb.sv
////////////////////////////////////////
// RX lane reset sequencer testbench
// Bring-up, link loss and time-out runs
////////////////////////////////////////
`include "rx_lane_defs.svh"

module rx_lane_rst_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int PHASE_SUM = `RXL_PD_CYCLES + `RXL_PMA_CYCLES + `RXL_CDR_CYCLES
                             + `RXL_PCS_CYCLES + `RXL_ALIGN_CYCLES + `RXL_DONE_DLY_CYCLES;
    localparam int CYCLE_LIMIT = 4 * PHASE_SUM * 5;   // Five scenarios
    localparam int WAIT_LIMIT  = 2 * PHASE_SUM;

    logic clk = 1'b0;
    logic rst_n;
    logic i_sigdet;
    logic i_cdr_align;
    logic i_word_align;
    logic o_lane_pd;
    logic o_pma_rst;
    logic o_pcs_rst;
    logic o_lane_done;

    int err_cnt = 0;
    int cycles  = 0;
    int seed    = 70965;

    rx_lane_rst u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_sigdet     (i_sigdet),
        .i_cdr_align  (i_cdr_align),
        .i_word_align (i_word_align),
        .o_lane_pd    (o_lane_pd),
        .o_pma_rst    (o_pma_rst),
        .o_pcs_rst    (o_pcs_rst),
        .o_lane_done  (o_lane_done)
    );

    always #50 clk = ~clk;

    // Watchdog on the whole run
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            err_cnt++;
            $display("Run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("Errors: %0d testbench, %0d assertion", err_cnt, u_dut.u_assert.fail_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int rand_gap();
        return 2 + ($unsigned($random(seed)) % 5);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Wait at falling edges for an output to reach a level
    task automatic wait_output(input int which, input logic level, input string name);
        int   n;
        logic val;
        n = 0;
        forever
        begin
            @(negedge clk);
            case (which)
                0:       val = o_lane_done;
                1:       val = o_pma_rst;
                default: val = o_pcs_rst;
            endcase
            if (val === level)
                break;
            n++;
            if (n >= WAIT_LIMIT)
            begin
                if (which == 0)
                    $display("MISMATCH o_lane_done exp 0x%0h got 0x%0h", level, val);
                else
                    $display("Timed out waiting for %s to reach %0d", name, level);
                err_cnt++;
                break;
            end
        end
    endtask

    task automatic drop_sigdet();
        @(posedge clk);
        i_sigdet <= 1'b0;
        idle_cycles(rand_gap());
        i_sigdet <= 1'b1;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        idle_cycles(3);
        rst_n <= 1'b1;
    endtask

    initial
    begin
        rst_n        = 1'b0;
        i_sigdet     = 1'b1;
        i_cdr_align  = 1'b1;
        i_word_align = 1'b1;
        idle_cycles(3);
        rst_n <= 1'b1;

        // 1: clean bring-up
        wait_output(0, 1'b1, "o_lane_done");
        idle_cycles(rand_gap());

        // 2: signal lost while done
        drop_sigdet();
        wait_output(0, 1'b1, "o_lane_done");

        // 3: CDR lock lost inside the PCS reset
        drop_sigdet();
        wait_output(1, 1'b0, "o_pma_rst");
        idle_cycles(3 + ($unsigned($random(seed)) % 4));
        i_cdr_align <= 1'b0;
        idle_cycles(rand_gap());
        i_cdr_align <= 1'b1;
        wait_output(0, 1'b1, "o_lane_done");

        // 4: alignment never comes
        @(posedge clk);
        i_word_align <= 1'b0;
        drop_sigdet();
        wait_output(2, 1'b0, "o_pcs_rst");
        wait_output(1, 1'b1, "o_pma_rst");
        @(posedge clk);
        i_word_align <= 1'b1;
        wait_output(0, 1'b1, "o_lane_done");

        // 5: fresh reset and clean bring-up
        apply_reset();
        wait_output(0, 1'b1, "o_lane_done");
        idle_cycles(4);

        $display("Errors: %0d testbench, %0d assertion", err_cnt, u_dut.u_assert.fail_cnt);
        if (err_cnt == 0 && u_dut.u_assert.fail_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/rx_lane_pkg.sv
verilog/rx_lane_timer.sv
verilog/rx_lane_seq.sv
verilog/rx_lane_ctrl.sv
verilog/rx_lane_rst.sv
tests/rx_lane_rst_assert.sv
tests/rx_lane_rst_tb.sv
